// File: src/scope_pkg.sv
// digitizer capture core shared definitions
// sample and stream widths, command codes, acquisition states, command word views

package scope_pkg;

	// ------------------------------------------------------------------------
	// sample and buffer geometry
	// ------------------------------------------------------------------------
	localparam int SAMPLE_W         = 12;           // one adc sample
	localparam int SAMPLES_PER_WORD = 4;            // samples per buffer word
	localparam int ADDR_W           = 8;            // default buffer address width
	localparam int STREAM_W         = 32;           // reply stream width
	localparam int CMD_BYTES        = 8;            // bytes per command
	localparam logic [31:0] FW_VERSION = 32'd19;    // reported by info selector 0

	typedef logic signed [SAMPLE_W-1:0] SAMPLE_T;
	typedef SAMPLE_T [SAMPLES_PER_WORD-1:0] SAMPLE_WORD_T;  // sample 0 in the low bits

	// ------------------------------------------------------------------------
	// encodings
	// ------------------------------------------------------------------------
	typedef enum logic [7:0] {
		CMD_READOUT  = 8'd0,    // stream buffer contents
		CMD_ARM      = 8'd1,    // arm trigger, return state
		CMD_INFO     = 8'd2,    // version or event count
		CMD_TRIG_SET = 8'd8     // thresholds and preoffset
	} CMD_T;

	typedef enum logic [7:0] {
		NONE     = 8'd0,        // fire as soon as armed
		RISING   = 8'd1,
		FALLING  = 8'd2,
		EXTERNAL = 8'd3
	} TRIG_TYPE_T;

	typedef enum logic [1:0] {
		ACQ_IDLE  = 2'd0,       // free running, waiting for arm
		ACQ_ARMED = 2'd1,       // looking for the trigger condition
		ACQ_POST  = 2'd2,       // taking post-trigger words
		ACQ_READY = 2'd3        // capture frozen until read out
	} ACQ_STATE_T;

	// one received command, byte 0 first on the wire and in the low bits
	typedef union packed {
		logic [CMD_BYTES-1:0][7:0] raw;
		struct packed {
			logic [31:0] length;    // bytes 7..4, little endian
			logic [23:0] spare;
			CMD_T        opcode;
		} readout;
		struct packed {
			logic [15:0] spare_hi;
			logic [15:0] post_len;  // bytes 5..4
			logic [15:0] spare_lo;
			TRIG_TYPE_T  trig_type;
			CMD_T        opcode;
		} arm;
		struct packed {
			logic [23:0] spare;
			logic [7:0]  preoff_lo;
			logic [7:0]  preoff_hi; // only bits 1:0 matter
			logic [7:0]  hyst;
			logic [7:0]  level;
			CMD_T        opcode;
		} trig;
	} CMD_WORD_U;

endpackage

// File: src/acq_ctrl_if.sv
// settings and status between command decode and acquisition control
// settings flow from the command side, status flows back from the trigger side

`timescale 1ns/100ps

interface acq_ctrl_if import scope_pkg::*; #(
	parameter int ADDR_W = scope_pkg::ADDR_W
);

	// settings, owned by the command processor
	TRIG_TYPE_T        trig_type;       // latched on arm command
	SAMPLE_T           lower_thresh;
	SAMPLE_T           upper_thresh;
	logic [15:0]       post_len;        // words taken after the trigger
	logic [9:0]        preoffset;       // words shown before the trigger
	logic              arm;             // single cycle, honoured in idle only
	logic              readout_done;    // single cycle, releases ready

	// status, owned by the trigger fsm
	ACQ_STATE_T        acq_state;
	logic [ADDR_W-1:0] trig_addr;       // buffer address of the trigger word
	logic [31:0]       event_count;

	modport cmd (
		output trig_type, lower_thresh, upper_thresh, post_len, preoffset,
		output arm, readout_done,
		input  acq_state, trig_addr, event_count
	);

	modport acq (
		input  trig_type, lower_thresh, upper_thresh, post_len, preoffset,
		input  arm, readout_done,
		output acq_state, trig_addr, event_count
	);

endinterface

// File: src/sample_conditioner.sv
// adc sample conditioning
// registers the four-sample word and inverts every sample, clipping at full scale

`timescale 1ns/100ps

module sample_conditioner import scope_pkg::*; (
	input  logic         clk,
	input  logic         rstn,
	input  SAMPLE_WORD_T i_samples,     // raw adc word, one per clock
	output SAMPLE_WORD_T o_samples      // inverted word, one clock later
);

	localparam SAMPLE_T SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};   // -2048
	localparam SAMPLE_T SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};   // +2047

	// the most negative code has no positive twin, pin it to full scale
	function automatic SAMPLE_T neg_sat(input SAMPLE_T s);
		if (s == SAMPLE_MIN) begin
			return SAMPLE_MAX;
		end
		return -s;
	endfunction

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_samples <= '0;
		end else begin
			for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
				o_samples[i] <= neg_sat(i_samples[i]);     // front end is inverting
			end
		end
	end

endmodule

// File: src/trigger_fsm.sv
// acquisition control
// runs the ring buffer write pointer, waits for the selected trigger,
// takes the post-trigger words and freezes the buffer until it is read

`timescale 1ns/100ps

module trigger_fsm import scope_pkg::*; #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              rstn,
	input  SAMPLE_WORD_T      i_samples,    // conditioned word being written now
	input  logic              i_ext_trig,   // level from another board
	output logic              o_trig_out,   // one pulse per real trigger
	output logic              o_wr_en,
	output logic [ADDR_W-1:0] o_wr_addr,
	acq_ctrl_if.acq           ctrl
);

	ACQ_STATE_T        state;
	logic              primed;          // first half of an edge condition seen
	logic [ADDR_W-1:0] wr_ptr;
	logic [15:0]       post_cnt;        // words written since the trigger
	logic              any_below;
	logic              any_above;
	logic              fire;

	assign o_wr_en        = (state != ACQ_READY);   // keep writing until frozen
	assign o_wr_addr      = wr_ptr;
	assign ctrl.acq_state = state;

	// ------------------------------------------------------------------------
	// threshold compare, all four samples of the word
	// ------------------------------------------------------------------------
	always_comb begin
		any_below = 1'b0;
		any_above = 1'b0;
		for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
			if ($signed(i_samples[i]) < ctrl.lower_thresh) begin
				any_below = 1'b1;
			end
			if ($signed(i_samples[i]) > ctrl.upper_thresh) begin
				any_above = 1'b1;
			end
		end
	end

	// trigger decision on the word written this cycle
	always_comb begin
		fire = 1'b0;
		case (state)
			ACQ_IDLE: fire = ctrl.arm && (ctrl.trig_type == NONE);  // immediate
			ACQ_ARMED: begin
				case (ctrl.trig_type)
					RISING:   fire = primed && any_above;   // was low, now high
					FALLING:  fire = primed && any_below;   // was high, now low
					EXTERNAL: fire = i_ext_trig;
					default:  fire = 1'b1;                  // type changed to none
				endcase
			end
			default: fire = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// state, pointers and counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state            <= ACQ_IDLE;
			primed           <= 1'b0;
			wr_ptr           <= '0;
			post_cnt         <= '0;
			o_trig_out       <= 1'b0;
			ctrl.trig_addr   <= '0;
			ctrl.event_count <= '0;
		end else begin
			o_trig_out <= fire && (ctrl.trig_type != NONE); // tell the others
			if (o_wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;                    // ring wraps naturally
			end
			if (fire) begin
				ctrl.trig_addr <= wr_ptr;                   // address of this word
				post_cnt       <= '0;
				primed         <= 1'b0;
				if (ctrl.post_len == '0) begin
					state            <= ACQ_READY;          // nothing more to take
					ctrl.event_count <= ctrl.event_count + 1'b1;
				end else begin
					state <= ACQ_POST;
				end
			end else begin
				case (state)
					ACQ_IDLE: begin
						if (ctrl.arm) begin
							primed <= 1'b0;
							state  <= ACQ_ARMED;
						end
					end
					ACQ_ARMED: begin
						if (!primed) begin
							if ((ctrl.trig_type == RISING && any_below) ||
							    (ctrl.trig_type == FALLING && any_above)) begin
								primed <= 1'b1;
							end
						end
					end
					ACQ_POST: begin
						post_cnt <= post_cnt + 1'b1;
						if (post_cnt + 16'd1 == ctrl.post_len) begin
							state            <= ACQ_READY;  // last word goes in now
							ctrl.event_count <= ctrl.event_count + 1'b1;
						end
					end
					ACQ_READY: begin
						if (ctrl.readout_done) begin
							state <= ACQ_IDLE;              // buffer released
						end
					end
					default: state <= ACQ_IDLE;
				endcase
			end
		end
	end

endmodule

// File: src/capture_ram.sv
// sample ring buffer
// simple dual port memory, one write and one registered read per clock

`timescale 1ns/100ps

module capture_ram import scope_pkg::*; #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic              clk,
	input  logic              i_wr_en,
	input  logic [ADDR_W-1:0] i_wr_addr,
	input  SAMPLE_WORD_T      i_wr_data,
	input  logic [ADDR_W-1:0] i_rd_addr,
	output SAMPLE_WORD_T      o_rd_data     // valid one clock after i_rd_addr
);

	localparam int DEPTH = 2 ** ADDR_W;

	SAMPLE_WORD_T mem [DEPTH];              // 48 bits per entry

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// same-address collision returns the old word
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

// File: src/command_processor.sv
// host command handling
// collects 8-byte commands from the byte stream, updates acquisition settings,
// answers on the 32-bit stream and streams the capture buffer on readout

`timescale 1ns/100ps

module command_processor import scope_pkg::*; #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic                  clk,
	input  logic                  rstn,
	// command byte stream in
	input  logic [7:0]            i_tdata,
	input  logic                  i_tvalid,
	output logic                  o_tready_rx,
	// reply stream out
	output logic [STREAM_W-1:0]   o_tdata,
	output logic                  o_tvalid,
	output logic [STREAM_W/8-1:0] o_tkeep,
	output logic                  o_tlast,
	input  logic                  i_tready,
	// buffer read port
	output logic [ADDR_W-1:0]     o_rd_addr,
	input  SAMPLE_WORD_T          i_rd_data,
	acq_ctrl_if.cmd               ctrl
);

	localparam logic [2:0] ST_INIT    = 3'd0;   // leave reset
	localparam logic [2:0] ST_RX      = 3'd1;   // take command bytes
	localparam logic [2:0] ST_DECODE  = 3'd2;   // act on the opcode
	localparam logic [2:0] ST_REPLY   = 3'd3;   // single word reply out
	localparam logic [2:0] ST_RD_ADDR = 3'd4;   // ram address settling
	localparam logic [2:0] ST_RD_LOAD = 3'd5;   // put next half word on the bus
	localparam logic [2:0] ST_RD_BEAT = 3'd6;   // wait for the beat to be taken

	logic [2:0]              state;
	logic [2:0]              rx_cnt;        // byte index within the command
	CMD_WORD_U               cmd;
	logic [31:0]             len;           // readout bytes still to send
	logic                    half;          // 0 sends samples 1:0, 1 sends 3:2
	logic [ADDR_W-1:0]       preoff_w;
	logic [11:0]             lo_base;
	logic [11:0]             hi_base;
	logic [STREAM_W-1:0]     beat;
	logic [STREAM_W/8-1:0]   keep_nxt;

	assign o_tready_rx = (state == ST_RX);
	assign preoff_w    = ADDR_W'(ctrl.preoffset);   // offset taken modulo buffer size

	// ------------------------------------------------------------------------
	// datapath helpers
	// ------------------------------------------------------------------------
	always_comb begin
		// level and hysteresis are 8-bit codes centred on 128
		lo_base = 12'(cmd.trig.level) - 12'(cmd.trig.hyst) - 12'd128;
		hi_base = 12'(cmd.trig.level) + 12'(cmd.trig.hyst) - 12'd128;
		if (half) begin
			beat = {4'b0, i_rd_data[3], 4'b0, i_rd_data[2]};
		end else begin
			beat = {4'b0, i_rd_data[1], 4'b0, i_rd_data[0]};
		end
		if (len >= 32'd4) begin
			keep_nxt = 4'b1111;
		end else begin
			case (len[1:0])
				2'd3:    keep_nxt = 4'b0111;
				2'd2:    keep_nxt = 4'b0011;
				2'd1:    keep_nxt = 4'b0001;
				default: keep_nxt = 4'b0000;
			endcase
		end
	end

	// command bytes land in wire order
	always_ff @(posedge clk) begin
		if (o_tready_rx && i_tvalid) begin
			cmd.raw[rx_cnt] <= i_tdata;
		end
	end

	// ------------------------------------------------------------------------
	// control fsm
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state             <= ST_INIT;
			rx_cnt            <= '0;
			len               <= '0;
			half              <= 1'b0;
			o_rd_addr         <= '0;
			o_tdata           <= '0;
			o_tvalid          <= 1'b0;
			o_tkeep           <= '0;
			o_tlast           <= 1'b0;
			ctrl.trig_type    <= NONE;
			ctrl.lower_thresh <= '0;
			ctrl.upper_thresh <= '0;
			ctrl.post_len     <= '0;
			ctrl.preoffset    <= '0;
			ctrl.arm          <= 1'b0;
			ctrl.readout_done <= 1'b0;
		end else begin
			ctrl.arm          <= 1'b0;     // pulses
			ctrl.readout_done <= 1'b0;
			case (state)
				ST_INIT: state <= ST_RX;
				ST_RX: begin
					if (i_tvalid) begin
						rx_cnt <= rx_cnt + 1'b1;        // wraps to 0 after byte 7
						if (rx_cnt == 3'(CMD_BYTES - 1)) begin
							state <= ST_DECODE;
						end
					end
				end
				ST_DECODE: begin
					o_tkeep <= 4'b1111;                 // single replies are full words
					o_tlast <= 1'b1;
					case (cmd.arm.opcode)
						CMD_READOUT: begin
							len       <= cmd.readout.length;
							half      <= 1'b0;
							o_rd_addr <= ctrl.trig_addr - preoff_w;  // show pre-trigger
							if (cmd.readout.length == '0) begin
								ctrl.readout_done <= 1'b1;
								state             <= ST_RX;
							end else begin
								state <= ST_RD_ADDR;
							end
						end
						CMD_ARM: begin
							ctrl.arm       <= 1'b1;
							ctrl.trig_type <= cmd.arm.trig_type;
							ctrl.post_len  <= cmd.arm.post_len;
							o_tdata        <= STREAM_W'(ctrl.acq_state);  // state before arm
							o_tvalid       <= 1'b1;
							state          <= ST_REPLY;
						end
						CMD_INFO: begin
							case (cmd.raw[1])
								8'd0:    o_tdata <= STREAM_W'(FW_VERSION);
								8'd3:    o_tdata <= STREAM_W'(ctrl.event_count);
								default: o_tdata <= '0;
							endcase
							o_tvalid <= 1'b1;
							state    <= ST_REPLY;
						end
						CMD_TRIG_SET: begin
							ctrl.lower_thresh <= SAMPLE_T'((lo_base << 4) + 12'd8);
							ctrl.upper_thresh <= SAMPLE_T'((hi_base << 4) + 12'd8);
							ctrl.preoffset    <= {cmd.trig.preoff_hi[1:0], cmd.trig.preoff_lo};
							o_tdata           <= STREAM_W'(CMD_TRIG_SET);   // echo opcode
							o_tvalid          <= 1'b1;
							state             <= ST_REPLY;
						end
						default: state <= ST_RX;        // unknown, drop silently
					endcase
				end
				ST_REPLY: begin
					if (i_tready) begin
						o_tvalid <= 1'b0;
						state    <= ST_RX;
					end
				end
				ST_RD_ADDR: state <= ST_RD_LOAD;        // ram output valid next cycle
				ST_RD_LOAD: begin
					o_tdata  <= beat;
					o_tkeep  <= keep_nxt;
					o_tlast  <= (len <= 32'd4);
					o_tvalid <= 1'b1;
					state    <= ST_RD_BEAT;
				end
				ST_RD_BEAT: begin
					if (i_tready) begin
						o_tvalid <= 1'b0;
						if (o_tlast) begin
							ctrl.readout_done <= 1'b1;  // frees the buffer
							state             <= ST_RX;
						end else begin
							len  <= len - 32'd4;
							half <= ~half;
							if (half) begin
								o_rd_addr <= o_rd_addr + 1'b1;  // both halves sent
								state     <= ST_RD_ADDR;
							end else begin
								state <= ST_RD_LOAD;    // same word, upper samples
							end
						end
					end
				end
				default: state <= ST_INIT;
			endcase
		end
	end

endmodule

// File: src/scope_top.sv
// digitizer control and capture core
// sample conditioning, triggered ring buffer capture and host command stream

`timescale 1ns/100ps

module scope_top import scope_pkg::*; #(
	parameter int ADDR_W = scope_pkg::ADDR_W
) (
	input  logic                clk,
	input  logic                rstn,
	// command stream from host
	input  logic [7:0]          i_tdata,
	input  logic                i_tvalid,
	output logic                o_tready_rx,
	// reply stream to host
	output logic [STREAM_W-1:0] o_tdata,
	output logic                o_tvalid,
	output logic [3:0]          o_tkeep,
	output logic                o_tlast,
	input  logic                i_tready,
	// adc and trigger lines
	input  SAMPLE_WORD_T        i_samples,
	input  logic                i_ext_trig,
	output logic                o_trig_out
);

	SAMPLE_WORD_T      cond_samples;    // inverted word, feeds fsm and ram
	SAMPLE_WORD_T      rd_data;
	logic              wr_en;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;

	acq_ctrl_if #(.ADDR_W(ADDR_W)) u_ctrl ();

	sample_conditioner u_cond (
		.clk       (clk),
		.rstn      (rstn),
		.i_samples (i_samples),
		.o_samples (cond_samples)
	);

	trigger_fsm #(.ADDR_W(ADDR_W)) u_trig (
		.clk        (clk),
		.rstn       (rstn),
		.i_samples  (cond_samples),
		.i_ext_trig (i_ext_trig),
		.o_trig_out (o_trig_out),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.ctrl       (u_ctrl.acq)
	);

	capture_ram #(.ADDR_W(ADDR_W)) u_ram (
		.clk       (clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (cond_samples),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	command_processor #(.ADDR_W(ADDR_W)) u_cmd (
		.clk         (clk),
		.rstn        (rstn),
		.i_tdata     (i_tdata),
		.i_tvalid    (i_tvalid),
		.o_tready_rx (o_tready_rx),
		.o_tdata     (o_tdata),
		.o_tvalid    (o_tvalid),
		.o_tkeep     (o_tkeep),
		.o_tlast     (o_tlast),
		.i_tready    (i_tready),
		.o_rd_addr   (rd_addr),
		.i_rd_data   (rd_data),
		.ctrl        (u_ctrl.cmd)
	);

endmodule

// File: dv/scope_checker.sv
// reply stream and trigger output checker
// bound into the core top level, watches beat stability, keep and pulse width

`timescale 1ns/100ps

module scope_checker import scope_pkg::*; (
	input logic                clk,
	input logic                rstn,
	input logic [STREAM_W-1:0] o_tdata,
	input logic                o_tvalid,
	input logic [3:0]          o_tkeep,
	input logic                o_tlast,
	input logic                i_tready,
	input logic                o_trig_out
);

	int assert_errs = 0;                    // failed assertions so far

	// a stalled beat stays on the bus unchanged
	a_hold: assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !i_tready) |=>
		(o_tvalid && $stable(o_tdata) && $stable(o_tkeep) && $stable(o_tlast)))
	else begin
		$error("reply beat changed or dropped while i_tready was low");
		assert_errs++;
	end

	// only the closing beat may be partial
	a_keep: assert property (@(posedge clk) disable iff (!rstn)
		(o_tvalid && !o_tlast) |-> (o_tkeep == 4'b1111))
	else begin
		$error("partial tkeep on a beat without tlast");
		assert_errs++;
	end

	a_trig: assert property (@(posedge clk) disable iff (!rstn)
		o_trig_out |=> !o_trig_out)     // single cycle pulse
	else begin
		$error("o_trig_out high for two cycles in a row");
		assert_errs++;
	end

endmodule

// File: dv/tb_scope_top.sv
// testbench for the digitizer capture core
// replays dv/scope_trace.txt, driving commands and sample patterns and checking replies

`timescale 1ns/100ps

module tb_scope_top import scope_pkg::*; ();

	localparam int TIMEOUT = 200;           // cycles per wait

	logic                clk;
	logic                rstn;
	logic [7:0]          i_tdata;
	logic                i_tvalid;
	logic                o_tready_rx;
	logic [STREAM_W-1:0] o_tdata;
	logic                o_tvalid;
	logic [3:0]          o_tkeep;
	logic                o_tlast;
	logic                i_tready;
	SAMPLE_WORD_T        i_samples;
	logic                i_ext_trig;
	logic                o_trig_out;

	integer       seed;
	int           errors;
	int           checks;
	int           tests;
	int           test_errs;                // errors when the test began
	string        test_name;
	bit           abort;                    // stop replaying after a timeout
	bit           ramp_on;
	int           ramp_start;               // first value of the running ramp
	int           ramp_val;
	SAMPLE_WORD_T level_word;
	SAMPLE_WORD_T pulse_word;
	bit           pulse_pending;            // one word, then back to level or ramp
	bit           ext_pending;
	int           trig_count;

	scope_top u_dut (
		.clk         (clk),
		.rstn        (rstn),
		.i_tdata     (i_tdata),
		.i_tvalid    (i_tvalid),
		.o_tready_rx (o_tready_rx),
		.o_tdata     (o_tdata),
		.o_tvalid    (o_tvalid),
		.o_tkeep     (o_tkeep),
		.o_tlast     (o_tlast),
		.i_tready    (i_tready),
		.i_samples   (i_samples),
		.i_ext_trig  (i_ext_trig),
		.o_trig_out  (o_trig_out)
	);

	bind scope_top scope_checker u_checker (
		.clk(clk), .rstn(rstn), .o_tdata(o_tdata), .o_tvalid(o_tvalid), .o_tkeep(o_tkeep),
		.o_tlast(o_tlast), .i_tready(i_tready), .o_trig_out(o_trig_out)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// ------------------------------------------------------------------------
	// background drivers, adc word, external trigger and reply back-pressure
	// ------------------------------------------------------------------------
	initial begin
		i_samples  = '0;
		i_ext_trig = 1'b0;
		i_tready   = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			i_tready    = (($random(seed) & 3) != 0);  // about one stall in four
			i_ext_trig  = ext_pending;
			ext_pending = 1'b0;
			if (pulse_pending) begin
				i_samples     = pulse_word;
				pulse_pending = 1'b0;
			end else if (ramp_on) begin
				for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
					i_samples[i] = SAMPLE_T'(ramp_val + i);    // step 1 per sample
				end
				ramp_val = ramp_val + SAMPLES_PER_WORD;
			end else begin
				i_samples = level_word;
			end
		end
	end

	always @(negedge clk) begin
		if (rstn && o_trig_out) begin
			trig_count = trig_count + 1;    // mid cycle, output is stable
		end
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------
	task automatic check_word(input string what, input logic [STREAM_W-1:0] exp,
		input logic [STREAM_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_sample(input string what, input SAMPLE_T exp, input SAMPLE_T act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic check_state(input ACQ_STATE_T exp, input ACQ_STATE_T act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s state: expected %s, actual %s", test_name, exp.name(),
				act.name());
		end
	endtask

	task automatic check_keep(input logic [3:0] exp, input logic [3:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s tkeep: expected %b, actual %b", test_name, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		abort = 1'b1;
		$display("timeout in %s: %s", test_name, what);
	endtask

	// bytes kept on a beat with this many bytes still to go
	function automatic logic [3:0] keep_for(input int left);
		if (left >= 4) begin
			return 4'b1111;
		end
		return 4'b1111 >> (4 - left);
	endfunction

	// ------------------------------------------------------------------------
	// stream tasks
	// ------------------------------------------------------------------------
	task automatic send_command(input CMD_WORD_U c);
		int t;
		@(posedge clk);
		#2;
		for (int i = 0; i < CMD_BYTES; i++) begin
			i_tdata  = c.raw[i];                // byte 0 goes first
			i_tvalid = 1'b1;
			t        = 0;
			@(negedge clk);
			while (!o_tready_rx && t < TIMEOUT) begin
				@(negedge clk);
				t++;
			end
			if (!o_tready_rx) begin
				i_tvalid = 1'b0;
				report_timeout($sformatf("command byte %0d never accepted", i));
				return;
			end
			@(posedge clk);                     // byte taken on this edge
			#2;
		end
		i_tvalid = 1'b0;
	endtask

	task automatic get_beat(output logic [STREAM_W-1:0] d, output logic [3:0] k,
		output logic l, output bit ok);
		int t;
		t  = 0;
		ok = 1'b0;
		d  = '0;
		k  = '0;
		l  = 1'b0;
		while (!ok && t < TIMEOUT) begin
			@(negedge clk);
			if (o_tvalid && i_tready) begin     // transfers on the next edge
				ok = 1'b1;
				d  = o_tdata;
				k  = o_tkeep;
				l  = o_tlast;
			end
			t++;
		end
		if (!ok) begin
			report_timeout("no reply beat arrived");
		end
	endtask

	// kind 0 expects silence, 1 a data word, 2 an acquisition state
	task automatic run_cmd(input int kind, input CMD_WORD_U c, input int exp);
		logic [STREAM_W-1:0] d;
		logic [3:0]          k;
		logic                l;
		bit                  ok;
		bit                  seen;
		int                  t;
		send_command(c);
		if (abort) begin
			return;
		end
		if (kind == 0) begin
			t    = 0;
			seen = 1'b0;
			@(negedge clk);
			while (!o_tready_rx && t < TIMEOUT) begin
				seen = seen | o_tvalid;
				@(negedge clk);
				t++;
			end
			check_flag("silent", 1'b0, seen | o_tvalid);
			if (!o_tready_rx) begin
				report_timeout("receiver never came back");
			end
			return;
		end
		get_beat(d, k, l, ok);
		if (!ok) begin
			return;
		end
		if (kind == 1) begin
			check_word("reply", STREAM_W'(exp), d);
		end else begin
			check_state(ACQ_STATE_T'(exp[1:0]), ACQ_STATE_T'(d[1:0]));
			check_word("reply upper bits", '0, {d[STREAM_W-1:2], 2'b00});
		end
		check_keep(4'b1111, k);
		check_flag("tlast", 1'b1, l);
	endtask

	// mode 0 checks a falling ramp, mode 1 the first buffer word
	task automatic run_read(input int len, input int mode, input SAMPLE_WORD_T first);
		CMD_WORD_U           c;
		logic [STREAM_W-1:0] d;
		logic [3:0]          k;
		logic                l;
		bit                  ok;
		SAMPLE_T             got [$];
		int                  nbeats;
		int                  first_drv;     // driven value behind the first sample read
		c                = '0;
		c.readout.opcode = CMD_READOUT;
		c.readout.length = len;
		send_command(c);
		if (abort) begin
			return;
		end
		nbeats = (len + 3) / 4;
		for (int b = 0; b < nbeats; b++) begin
			get_beat(d, k, l, ok);
			if (!ok) begin
				return;
			end
			check_keep(keep_for(len - 4 * b), k);
			check_flag("tlast", b == nbeats - 1, l);
			check_word("pad nibbles", '0, d & 32'hf000_f000);
			if (k[1]) begin
				got.push_back(SAMPLE_T'(d[11:0]));
			end
			if (k[3]) begin
				got.push_back(SAMPLE_T'(d[27:16]));
			end
		end
		if (mode == 0) begin
			if (got.size() > 0) begin
				first_drv = -int'(got[0]);      // front end inverts
				check_flag("ramp origin", 1'b1,
					first_drv >= ramp_start && first_drv + got.size() <= ramp_val);
			end
			for (int j = 1; j < got.size(); j++) begin
				check_sample($sformatf("ramp step %0d", j), SAMPLE_T'(got[j-1] - 1), got[j]);
			end
		end else begin
			check_count("samples read", SAMPLES_PER_WORD, got.size());
			for (int j = 0; j < SAMPLES_PER_WORD && j < got.size(); j++) begin
				check_sample($sformatf("sample %0d", j), first[j], got[j]);
			end
		end
	endtask

	task automatic begin_test(input logic [8*16-1:0] name);
		tests++;
		test_name = $sformatf("%0s", name);
		test_errs = errors;
	endtask

	task automatic end_test();
		$display("test %-12s %s", test_name, (errors == test_errs) ? "ok" : "mismatch");
	endtask

	// ------------------------------------------------------------------------
	// trace replay
	// ------------------------------------------------------------------------
	initial begin
		integer           fd;
		integer           r;
		int               v;
		int               mode;
		int               e [4];
		logic [8*16-1:0]  kw;
		logic [8*16-1:0]  name;
		logic [8*16-1:0]  kind;
		logic [8*128-1:0] line;
		CMD_WORD_U        c;
		SAMPLE_WORD_T     w;
		seed          = 54;
		errors        = 0;
		checks        = 0;
		tests         = 0;
		abort         = 1'b0;
		ramp_on       = 1'b0;
		ramp_start    = 0;
		ramp_val      = 0;
		level_word    = '0;
		pulse_word    = '0;
		pulse_pending = 1'b0;
		ext_pending   = 1'b0;
		trig_count    = 0;
		i_tdata       = '0;
		i_tvalid      = 1'b0;
		rstn          = 1'b0;

		begin_test("reset");
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_flag("o_tvalid in reset", 1'b0, o_tvalid);
		check_flag("o_tready_rx in reset", 1'b0, o_tready_rx);
		check_flag("o_trig_out in reset", 1'b0, o_trig_out);
		@(posedge clk);
		#2 rstn = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check_flag("o_tready_rx after reset", 1'b1, o_tready_rx);
		end_test();

		fd = $fopen("dv/scope_trace.txt", "r");
		if (fd == 0) begin
			errors++;
			abort = 1'b1;
			$display("cannot open dv/scope_trace.txt");
		end
		while (!abort && $fscanf(fd, "%s", kw) == 1) begin
			if (kw == "#") begin
				r = $fgets(line, fd);               // column notes
			end else if (kw == "cmd") begin
				r = $fscanf(fd, "%s %s", name, kind);
				for (int i = 0; i < CMD_BYTES; i++) begin
					r        = $fscanf(fd, "%h", v);
					c.raw[i] = v[7:0];
				end
				r = $fscanf(fd, "%d", v);
				begin_test(name);
				run_cmd((kind == "none") ? 0 : (kind == "word") ? 1 : 2, c, v);
				end_test();
			end else if (kw == "read") begin
				r = $fscanf(fd, "%s %d %s %d %d %d %d", name, v, kind, e[0], e[1], e[2], e[3]);
				mode = (kind == "ramp") ? 0 : 1;
				for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
					w[i] = SAMPLE_T'(e[i]);
				end
				begin_test(name);
				run_read(v, mode, w);
				end_test();
			end else if (kw == "trigs") begin
				r = $fscanf(fd, "%s %d", name, v);
				begin_test(name);
				check_count("trigger pulses", v, trig_count);
				trig_count = 0;
				end_test();
			end else if (kw == "ramp") begin
				r = $fscanf(fd, "%d", v);
				@(posedge clk);
				ramp_start = v;
				ramp_val   = v;
				ramp_on    = 1'b1;
			end else if (kw == "level") begin
				r = $fscanf(fd, "%d", v);
				@(posedge clk);
				ramp_on = 1'b0;
				for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
					level_word[i] = SAMPLE_T'(v);
				end
			end else if (kw == "pulse") begin
				r = $fscanf(fd, "%d %d %d %d", e[0], e[1], e[2], e[3]);
				@(posedge clk);
				for (int i = 0; i < SAMPLES_PER_WORD; i++) begin
					pulse_word[i] = SAMPLE_T'(e[i]);
				end
				pulse_pending = 1'b1;
			end else if (kw == "ext") begin
				@(posedge clk);
				ext_pending = 1'b1;
			end else if (kw == "idle") begin
				r = $fscanf(fd, "%d", v);
				repeat (v) @(posedge clk);
			end else begin
				errors++;
				abort = 1'b1;
				$display("unknown directive %0s in the trace", kw);
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		repeat (4) @(posedge clk);
		if (u_dut.u_checker.assert_errs != 0) begin
			errors += u_dut.u_checker.assert_errs;
			$display("stream checker reported %0d assertion failures",
				u_dut.u_checker.assert_errs);
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: scope_top.f
src/scope_pkg.sv
src/acq_ctrl_if.sv
src/sample_conditioner.sv
src/trigger_fsm.sv
src/capture_ram.sv
src/command_processor.sv
src/scope_top.sv
dv/scope_checker.sv
dv/tb_scope_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_scope_top
FILELIST = scope_top.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/scope_trace.txt
# keyword name fields, one directive per line, bytes in hex, values in decimal
# cmd name kind(none word state) b0..b7 expected | read name bytes mode(ramp first) e0..e3
cmd   unknown     none  55 00 00 00 00 00 00 00 0
cmd   info_ver    word  02 00 00 00 00 00 00 00 19
ramp  100
cmd   trig_set    word  08 80 08 00 02 00 00 00 8
idle  8
cmd   arm_idle    state 01 00 00 00 04 00 00 00 0
idle  12
cmd   arm_ready   state 01 00 00 00 04 00 00 00 3
read  ramp_rd     10 ramp 0 0 0 0
level 500
cmd   trig_zero   word  08 80 08 00 00 00 00 00 8
cmd   arm_rise    state 01 01 00 00 04 00 00 00 0
idle  4
pulse -700 -701 -702 -703
idle  12
trigs rise_pulse  1
read  rise_rd     8 first 700 701 702 703
cmd   evt_before  word  02 03 00 00 00 00 00 00 2
cmd   arm_ext     state 01 03 00 00 02 00 00 00 0
idle  4
ext
idle  8
trigs ext_pulse   1
cmd   arm_ext_rdy state 01 03 00 00 02 00 00 00 3
cmd   evt_after   word  02 03 00 00 00 00 00 00 3
read  ext_rd      8 first -500 -500 -500 -500
level -2048
idle  4
cmd   arm_sat     state 01 00 00 00 04 00 00 00 0
idle  12
read  sat_rd      8 first 2047 2047 2047 2047
